// ==== hw/bundleAlign.sv ====
// fetch window select, op length and WEX step decode, stall bundle output
`timescale 1ns/100ps

module bundleAlign (
	input  icachePkg::lineData   evenData,
	input  icachePkg::lineData   oddData,
	input  icachePkg::fetchAddr  reqAddr,
	input  logic                 hold,
	input  logic                 wexEnable,
	output icachePkg::bundle     pcBundle,
	output icachePkg::pcStep     pcStep,
	output icachePkg::fetchOk    pcOk
);

	logic [255:0]     joined;   // next line above current line
	icachePkg::bundle window;
	logic [6:0]       bitOffset;
	logic             firstLong;
	logic             firstWex;
	logic             secondWex;
	icachePkg::pcStep opStep;

	// top three bits all set marks a 32-bit op
	function automatic logic isLongOp(input logic [15:0] word);
		isLongOp = (word[15:13] == 3'b111);
	endfunction

	assign joined    = reqAddr[4] ? {evenData, oddData} : {oddData, evenData};
	assign bitOffset = {reqAddr[3:1], 4'b0000};
	assign window    = joined[bitOffset +: 96];

	assign firstLong = isLongOp(window[15:0]);
	assign firstWex  = firstLong && window[10];
	assign secondWex = isLongOp(window[47:32]) && window[42]; // op right after a 32-bit first

	always_comb
	begin
		if (wexEnable && firstWex)
			opStep = secondWex ? 4'd12 : 4'd8;
		else if (firstLong)
			opStep = 4'd4;
		else
			opStep = 4'd2;
	end

	always_comb
	begin
		if (hold)
		begin
			pcBundle = icachePkg::stallBundle;
			pcStep   = 4'd0;
			pcOk     = icachePkg::FETCH_HOLD;
		end
		else
		begin
			pcBundle = window;
			pcStep   = opStep;
			pcOk     = icachePkg::FETCH_OK;
		end
	end

endmodule

// ==== hw/fetchAddress.sv ====
// fetch PC capture, even/odd line addresses and bank read indices
`timescale 1ns/100ps

module fetchAddress (
	input  logic                 clock,
	input  logic                 reset,
	input  icachePkg::fetchAddr  pc,
	input  logic                 pcHold,
	input  logic                 hold,
	output icachePkg::fetchAddr  reqAddr,
	output icachePkg::lineAddr   evenLine,
	output icachePkg::lineAddr   oddLine,
	output icachePkg::lineIndex  evenIndex,
	output icachePkg::lineIndex  oddIndex,
	output icachePkg::lineIndex  readEvenIndex,
	output icachePkg::lineIndex  readOddIndex
);

	icachePkg::lineAddr pcLine;
	icachePkg::lineAddr nextLine;
	icachePkg::lineAddr nxtEven;
	icachePkg::lineAddr nxtOdd;
	logic               stall;

	assign pcLine   = pc[31:4];
	assign nextLine = pcLine + 28'd1; // window may spill into this one
	assign stall    = pcHold || hold;

	// PC bit 4 is line bit 0, so it picks the bank of the current line
	always_comb
	begin
		if (pc[4])
		begin
			nxtOdd  = pcLine;
			nxtEven = nextLine;
		end
		else
		begin
			nxtEven = pcLine;
			nxtOdd  = nextLine;
		end
	end

	// re-read the held lines so a fill shows up on the next lookup
	assign readEvenIndex = stall ? evenIndex : nxtEven[6:1];
	assign readOddIndex  = stall ? oddIndex : nxtOdd[6:1];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reqAddr   <= '0;
			evenLine  <= '0;
			oddLine   <= 28'd1;
			evenIndex <= '0;
			oddIndex  <= '0;
		end
		else if (!stall)
		begin
			reqAddr   <= pc;
			evenLine  <= nxtEven;
			oddLine   <= nxtOdd;
			evenIndex <= nxtEven[6:1];
			oddIndex  <= nxtOdd[6:1];
		end
	end

	evenLineAligned: assert property (@(posedge clock) disable iff (reset)
		evenLine[0] == 1'b0);

endmodule

// ==== hw/icachePkg.sv ====
// cache geometry, address/line/bundle types, fetch status codes and stall bundle
package icachePkg;

	typedef logic [31:0]  fetchAddr; // PC
	typedef logic [27:0]  lineAddr;  // PC bits 31..4
	typedef logic [5:0]   lineIndex; // line address bits 6..1
	typedef logic [127:0] lineData;
	typedef logic [95:0]  bundle;    // fetch window
	typedef logic [3:0]   pcStep;    // bytes
	typedef logic [2:0]   roverVal;
	typedef logic [9:0]   retryCount;

	typedef enum logic [1:0]
	{
		FETCH_OK   = 2'b00,
		FETCH_HOLD = 2'b01
	} fetchOk;

	localparam int linesPerBank = 64;

	// three no-op words, shown while the pipeline waits
	localparam bundle stallBundle = {3{32'h30023002}};

	// cycles a load may stay unanswered before it is sent again
	localparam retryCount missRetryCycles = 10'd1023;

endpackage

// ==== hw/icacheTop.sv ====
// two-bank instruction cache top with fetch, array, ring and align blocks
`timescale 1ns/100ps

module icacheTop (
	input  logic                clock,
	input  logic                reset,
	input  icachePkg::fetchAddr pc,
	input  logic                pcHold,
	input  logic                wexEnable,
	input  logic                flush,
	input  ringPkg::ringOpm     ringOpmIn,
	input  ringPkg::ringSeq     ringSeqIn,
	input  ringPkg::ringAddr    ringAddrIn,
	input  ringPkg::ringData    ringDataIn,
	output ringPkg::ringOpm     ringOpmOut,
	output ringPkg::ringSeq     ringSeqOut,
	output ringPkg::ringAddr    ringAddrOut,
	output ringPkg::ringData    ringDataOut,
	output icachePkg::bundle    pcBundle,
	output icachePkg::pcStep    pcStep,
	output icachePkg::fetchOk   pcOk
);

	icachePkg::fetchAddr reqAddr;
	icachePkg::lineAddr  evenLine;
	icachePkg::lineAddr  oddLine;
	icachePkg::lineIndex evenIndex;
	icachePkg::lineIndex oddIndex;
	icachePkg::lineIndex readEvenIndex;
	icachePkg::lineIndex readOddIndex;
	icachePkg::lineData  evenData;
	icachePkg::lineData  oddData;
	logic                evenMiss;
	logic                oddMiss;
	logic                hold;
	logic                fillEven;
	logic                fillOdd;
	icachePkg::lineIndex fillIndex;
	icachePkg::lineAddr  fillLine;
	icachePkg::lineData  fillData;

	fetchAddress fetchAddress_inst (
		.clock, .reset, .pc, .pcHold, .hold,
		.reqAddr, .evenLine, .oddLine, .evenIndex, .oddIndex,
		.readEvenIndex, .readOddIndex
	);

	lineStore lineStore_inst (
		.clock, .reset, .flush, .readEvenIndex, .readOddIndex,
		.evenLine, .oddLine, .evenIndex,
		.fillEven, .fillOdd, .fillIndex, .fillLine, .fillData,
		.evenData, .oddData, .evenMiss, .oddMiss, .hold
	);

	missRingNode missRingNode_inst (
		.clock, .reset, .evenMiss, .oddMiss, .hold,
		.evenLine, .oddLine, .evenIndex, .oddIndex,
		.ringOpmIn, .ringSeqIn, .ringAddrIn, .ringDataIn,
		.ringOpmOut, .ringSeqOut, .ringAddrOut, .ringDataOut,
		.fillEven, .fillOdd, .fillIndex, .fillLine, .fillData
	);

	bundleAlign bundleAlign_inst (
		.evenData, .oddData, .reqAddr, .hold, .wexEnable,
		.pcBundle, .pcStep, .pcOk
	);

endmodule

// ==== hw/lineStore.sv ====
// even and odd line banks with registered read, tag/rover compare, fill and flush
`timescale 1ns/100ps

module lineStore (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 flush,
	input  icachePkg::lineIndex  readEvenIndex,
	input  icachePkg::lineIndex  readOddIndex,
	input  icachePkg::lineAddr   evenLine,
	input  icachePkg::lineAddr   oddLine,
	input  icachePkg::lineIndex  evenIndex,
	input  logic                 fillEven,
	input  logic                 fillOdd,
	input  icachePkg::lineIndex  fillIndex,
	input  icachePkg::lineAddr   fillLine,
	input  icachePkg::lineData   fillData,
	output icachePkg::lineData   evenData,
	output icachePkg::lineData   oddData,
	output logic                 evenMiss,
	output logic                 oddMiss,
	output logic                 hold
);

	// bank 0 is even, bank 1 is odd
	icachePkg::lineData  dataArr [2][icachePkg::linesPerBank];
	icachePkg::lineAddr  tagArr [2][icachePkg::linesPerBank];
	icachePkg::roverVal  rovArr [2][icachePkg::linesPerBank];

	icachePkg::lineIndex readIndex [2];
	icachePkg::lineAddr  lookupLine [2];
	icachePkg::lineData  dataQ [2];
	icachePkg::lineAddr  tagQ [2];
	icachePkg::roverVal  rovQ [2];
	icachePkg::lineIndex evenReadQ;
	logic [1:0]          fillBank;
	logic [1:0]          miss;
	icachePkg::roverVal  rover;
	logic                armed;   // lookups count from the first edge out of reset
	logic                fillLast;

	assign readIndex[0]  = readEvenIndex;
	assign readIndex[1]  = readOddIndex;
	assign lookupLine[0] = evenLine;
	assign lookupLine[1] = oddLine;
	assign fillBank      = {fillOdd, fillEven};

	initial
	begin
		for (int b = 0; b < 2; b++)
		begin
			for (int i = 0; i < icachePkg::linesPerBank; i++)
			begin
				dataArr[b][i] = '0;
				tagArr[b][i]  = '0;
				rovArr[b][i]  = '0; // rover 0 is never current
			end
		end
	end

	always @(posedge clock)
	begin
		for (int b = 0; b < 2; b++)
		begin
			dataQ[b] <= dataArr[b][readIndex[b]];
			tagQ[b]  <= tagArr[b][readIndex[b]];
			rovQ[b]  <= rovArr[b][readIndex[b]];
			if (fillBank[b])
			begin
				dataArr[b][fillIndex] <= fillData;
				tagArr[b][fillIndex]  <= fillLine;
				rovArr[b][fillIndex]  <= rover;
			end
		end
		evenReadQ <= readEvenIndex;
	end

	always_comb
	begin
		for (int b = 0; b < 2; b++)
			miss[b] = armed && ((tagQ[b] != lookupLine[b]) || (rovQ[b] != rover));
	end

	assign evenData = dataQ[0];
	assign oddData  = dataQ[1];
	assign evenMiss = miss[0];
	assign oddMiss  = miss[1];
	assign hold     = (|miss) || (|fillBank) || fillLast; // read lags the write by one

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			rover    <= 3'd1;
			armed    <= 1'b0;
			fillLast <= 1'b0;
		end
		else
		begin
			armed    <= 1'b1;
			fillLast <= |fillBank;
			if (flush)
				rover <= (rover == 3'd7) ? 3'd1 : 3'(rover + 3'd1); // skip 0
		end
	end

	// one response names one bank
	singleFillBank: assert property (@(posedge clock) disable iff (reset)
		!(fillEven && fillOdd));

	// recirculation keeps the array read in step with the address register
	readInStep: assert property (@(posedge clock) disable iff (reset)
		armed |-> (evenReadQ == evenIndex));

endmodule

// ==== hw/missRingNode.sv ====
// miss request FSM, sequence tag table, ring forward/inject, fill decode, retry timer
`timescale 1ns/100ps

module missRingNode (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 evenMiss,
	input  logic                 oddMiss,
	input  logic                 hold,
	input  icachePkg::lineAddr   evenLine,
	input  icachePkg::lineAddr   oddLine,
	input  icachePkg::lineIndex  evenIndex,
	input  icachePkg::lineIndex  oddIndex,
	input  ringPkg::ringOpm      ringOpmIn,
	input  ringPkg::ringSeq      ringSeqIn,
	input  ringPkg::ringAddr     ringAddrIn,
	input  ringPkg::ringData     ringDataIn,
	output ringPkg::ringOpm      ringOpmOut,
	output ringPkg::ringSeq      ringSeqOut,
	output ringPkg::ringAddr     ringAddrOut,
	output ringPkg::ringData     ringDataOut,
	output logic                 fillEven,
	output logic                 fillOdd,
	output icachePkg::lineIndex  fillIndex,
	output icachePkg::lineAddr   fillLine,
	output icachePkg::lineData   fillData
);

	typedef enum logic [1:0]
	{
		MISS_IDLE,
		MISS_PENDING,
		MISS_RETRY
	} missState;

	missState             state;
	ringPkg::seqTag       tagRov;  // rolling tag for the next request
	ringPkg::seqTag       respTag;
	icachePkg::lineIndex  seqIndexTab [ringPkg::seqTagCount];
	icachePkg::lineAddr   seqLineTab [ringPkg::seqTagCount];
	icachePkg::retryCount retryTimer;
	logic                 sentEven;
	logic                 sentOdd;
	logic                 inResp;
	logic                 slotFree;
	logic                 isFill;
	logic [1:0]           respBank;
	logic                 canIssue;
	logic                 reqEven;
	logic                 reqOdd;
	logic                 inject;
	logic [1:0]           reqBank;
	icachePkg::lineIndex  reqIndex;
	icachePkg::lineAddr   reqLine;

	assign inResp = (ringOpmIn[ringPkg::opmClassLsb +: 2] == ringPkg::respClass) &&
		(ringSeqIn[ringPkg::seqNodeLsb +: 8] == ringPkg::nodeId);
	assign slotFree = (ringOpmIn == ringPkg::opmIdle) || inResp; // our response frees the slot
	assign isFill   = inResp && (ringOpmIn[ringPkg::opmStatusLsb +: 2] == ringPkg::respOk);
	assign respBank = ringSeqIn[ringPkg::seqBankLsb +: 2];
	assign respTag  = ringSeqIn[3:0];

	assign fillEven  = isFill && (respBank == ringPkg::bankEven);
	assign fillOdd   = isFill && (respBank == ringPkg::bankOdd);
	assign fillIndex = seqIndexTab[respTag];
	assign fillLine  = seqLineTab[respTag];
	assign fillData  = ringDataIn;

	// even bank first; a retry sends again what was already sent
	assign canIssue = hold && (state != MISS_PENDING);
	assign reqEven  = canIssue && evenMiss && (!sentEven || (state == MISS_RETRY));
	assign reqOdd   = canIssue && oddMiss && (!sentOdd || (state == MISS_RETRY)) && !reqEven;
	assign inject   = slotFree && (reqEven || reqOdd);
	assign reqBank  = reqEven ? ringPkg::bankEven : ringPkg::bankOdd;
	assign reqIndex = reqEven ? evenIndex : oddIndex;
	assign reqLine  = reqEven ? evenLine : oddLine;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state      <= MISS_IDLE;
			tagRov     <= '0;
			sentEven   <= 1'b0;
			sentOdd    <= 1'b0;
			retryTimer <= icachePkg::missRetryCycles;
		end
		else
		begin
			unique case (state)
				MISS_IDLE, MISS_RETRY:
				begin
					if (inject)
					begin
						state      <= MISS_PENDING;
						retryTimer <= icachePkg::missRetryCycles;
					end
					else if (!evenMiss && !oddMiss)
						state <= MISS_IDLE; // a late fill made the retry moot
				end
				MISS_PENDING:
				begin
					if (isFill || !hold)
						state <= MISS_IDLE;
					else if (retryTimer == '0)
						state <= MISS_RETRY;
					else
						retryTimer <= retryTimer - 1'b1;
				end
				default:
					state <= MISS_IDLE;
			endcase
			if (inject)
				tagRov <= tagRov + 4'd1;
			sentEven <= hold && (sentEven || (inject && reqEven)); // cleared once fetch moves on
			sentOdd  <= hold && (sentOdd || (inject && reqOdd));
		end
	end

	always_ff @(posedge clock)
	begin
		if (inject)
		begin
			seqIndexTab[tagRov] <= reqIndex;
			seqLineTab[tagRov]  <= reqLine;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ringOpmOut <= ringPkg::opmIdle;
			ringSeqOut <= '0;
		end
		else if (slotFree)
		begin
			ringOpmOut <= inject ? ringPkg::opmLoadLine : ringPkg::opmIdle;
			ringSeqOut <= inject ? {ringPkg::nodeId, reqBank, 2'b00, tagRov} : '0;
		end
		else
		begin
			ringOpmOut <= ringOpmIn; // traffic for others
			ringSeqOut <= ringSeqIn;
		end
	end

	always_ff @(posedge clock)
	begin
		if (slotFree)
		begin
			ringAddrOut <= inject ? {reqLine, 4'h0} : '0;
			ringDataOut <= '0;
		end
		else
		begin
			ringAddrOut <= ringAddrIn;
			ringDataOut <= ringDataIn;
		end
	end

	// own loads only leave while the fetch side is stalled
	requestOnlyOnHold: assert property (@(posedge clock) disable iff (reset)
		((ringOpmOut == ringPkg::opmLoadLine) &&
		(ringSeqOut[ringPkg::seqNodeLsb +: 8] == ringPkg::nodeId)) |-> $past(hold));

endmodule

// ==== hw/ringPkg.sv ====
// ring bus field types, opcodes, response codes, node id and field positions
package ringPkg;

	typedef logic [15:0]  ringOpm;  // operation mode
	typedef logic [15:0]  ringSeq;  // node, bank, tag
	typedef logic [31:0]  ringAddr;
	typedef logic [127:0] ringData; // one line tile
	typedef logic [3:0]   seqTag;

	localparam ringOpm opmIdle     = 16'h0000;
	localparam ringOpm opmLoadLine = 16'h0083; // line load request

	localparam logic [1:0] respClass = 2'b01; // opm bits 7..6 of a response
	localparam logic [1:0] respOk    = 2'b11; // opm bits 5..4, load done

	localparam logic [7:0] nodeId      = 8'h21;
	localparam int         seqTagCount = 16;

	// positions inside opm and seq
	localparam int opmClassLsb  = 6;
	localparam int opmStatusLsb = 4;
	localparam int seqNodeLsb   = 8;
	localparam int seqBankLsb   = 6;

	localparam logic [1:0] bankEven = 2'b00;
	localparam logic [1:0] bankOdd  = 2'b01;

endpackage

// ==== sources.f ====
hw/ringPkg.sv
hw/icachePkg.sv
hw/fetchAddress.sv
hw/lineStore.sv
hw/missRingNode.sv
hw/bundleAlign.sv
hw/icacheTop.sv
tests/ringMemoryModel.sv
tests/icacheTb.sv

// ==== tests/icacheTb.sv ====
// instruction cache testbench with vector reader, fetch driver, reference model and checks
`timescale 1ns/100ps

module icacheTb;

	localparam int timeoutCycles = 3000;
	localparam int memWordCount  = 512;
	localparam int randomFetches = 20;

	logic                clock;
	logic                reset;
	icachePkg::fetchAddr pc;
	logic                pcHold;
	logic                wexEnable;
	logic                flush;
	ringPkg::ringOpm     memOpm;
	ringPkg::ringSeq     memSeq;
	ringPkg::ringAddr    memAddr;
	ringPkg::ringData    memData;
	ringPkg::ringOpm     cacheOpm;
	ringPkg::ringSeq     cacheSeq;
	ringPkg::ringAddr    cacheAddr;
	ringPkg::ringData    cacheData;
	icachePkg::bundle    pcBundle;
	icachePkg::pcStep    pcStep;
	icachePkg::fetchOk   pcOk;

	logic [31:0]         memNow [memWordCount];   // what the ring memory holds now
	logic [31:0]         expImage [memWordCount]; // what the cache should hand out
	logic                validModel [128];
	icachePkg::lineAddr  tagModel [128];
	icachePkg::fetchAddr lastPc;
	logic [15:0]         lfsrState;
	logic [7:0]          cmdQ [$];
	logic [31:0]         argAQ [$];
	logic [31:0]         argBQ [$];
	logic [7:0]          cmd;
	logic [31:0]         argA;
	logic [31:0]         argB;
	logic [15:0]         pcBits;
	logic [15:0]         wexBit;

	icacheTop icacheTop_inst (
		.clock, .reset, .pc, .pcHold, .wexEnable, .flush,
		.ringOpmIn(memOpm), .ringSeqIn(memSeq), .ringAddrIn(memAddr), .ringDataIn(memData),
		.ringOpmOut(cacheOpm), .ringSeqOut(cacheSeq), .ringAddrOut(cacheAddr),
		.ringDataOut(cacheData), .pcBundle, .pcStep, .pcOk
	);

	ringMemoryModel memoryModel (
		.clock, .reset, .opmIn(cacheOpm), .seqIn(cacheSeq), .addrIn(cacheAddr),
		.opmOut(memOpm), .seqOut(memSeq), .addrOut(memAddr), .dataOut(memData)
	);

	always #5 clock = ~clock;

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping at first error");
	endtask

	task automatic checkValue(input string name, input logic [127:0] got,
		input logic [127:0] expected);
		if (got !== expected)
			failRun($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, name, got,
				expected));
	endtask

	// Galois form, taps 16 14 13 11
	function automatic logic [15:0] drawBits(input int count);
		logic [15:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			value     = {value[14:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
		end
		drawBits = value;
	endfunction

	function automatic logic [31:0] fillWord(input logic [8:0] index);
		fillWord = {4'h5, index, 3'h2, 4'h1, index, 3'h4}; // both halves are short ops
	endfunction

	function automatic logic [15:0] halfword(input logic [31:0] byteAddr);
		logic [31:0] word;
		word     = expImage[byteAddr[10:2]];
		halfword = byteAddr[1] ? word[31:16] : word[15:0];
	endfunction

	function automatic logic [95:0] expectedWindow(input logic [31:0] addr);
		logic [95:0] window;
		for (int k = 0; k < 6; k++)
			window[16*k +: 16] = halfword(addr + 32'(2 * k));
		expectedWindow = window;
	endfunction

	// 16-bit op unless the top three bits are set, WEX in bit 10
	function automatic logic [3:0] expectedStep(input logic [31:0] addr, input logic wex);
		logic [15:0] first;
		logic [15:0] second;
		logic        firstLong;
		first     = halfword(addr);
		second    = halfword(addr + 32'd4);
		firstLong = (first[15:13] == 3'b111);
		if (wex && firstLong && first[10])
			expectedStep = ((second[15:13] == 3'b111) && second[10]) ? 4'd12 : 4'd8;
		else
			expectedStep = firstLong ? 4'd4 : 4'd2;
	endfunction

	function automatic logic lineCached(input icachePkg::lineAddr line);
		lineCached = validModel[line[6:0]] && (tagModel[line[6:0]] == line);
	endfunction

	// a newly loaded line picks up the memory contents of that moment
	task automatic noteLoaded(input icachePkg::lineAddr line);
		if (!lineCached(line))
		begin
			validModel[line[6:0]] = 1'b1;
			tagModel[line[6:0]]   = line;
			for (int k = 0; k < 4; k++)
				expImage[{line[6:0], 2'(k)}] = memNow[{line[6:0], 2'(k)}];
		end
	endtask

	task automatic writeWord(input logic [8:0] index, input logic [31:0] value,
		input logic intoImage);
		memNow[index]                = value;
		memoryModel.memWords[index] = value;
		if (intoImage)
			expImage[index] = value;
	endtask

	task automatic waitOk(input string what);
		int count;
		count = 0;
		while (pcOk != icachePkg::FETCH_OK)
		begin
			if (count == timeoutCycles)
				failRun($sformatf("Timeout: pcOk stayed on hold for %0d cycles during %s",
					timeoutCycles, what));
			@(posedge clock);
			#1;
			count++;
		end
	endtask

	// the held PC misses after reset or flush and reloads its two lines
	task automatic settleHeld();
		repeat (2) @(posedge clock);
		#1;
		waitOk("reload of the held lines");
		noteLoaded(lastPc[31:4]);
		noteLoaded(lastPc[31:4] + 28'd1);
	endtask

	task automatic runFetch(input icachePkg::fetchAddr addr, input logic wex);
		icachePkg::lineAddr line;
		logic               hitBoth;
		line = addr[31:4];
		waitOk("wait before a fetch");
		hitBoth   = lineCached(line) && lineCached(line + 28'd1);
		pc        = addr;
		pcHold    = 1'b0;
		wexEnable = wex;
		@(posedge clock);
		#1;
		pcHold = 1'b1;
		lastPc = addr;
		checkValue("pcOk", pcOk, hitBoth ? icachePkg::FETCH_OK : icachePkg::FETCH_HOLD);
		if (!hitBoth)
		begin
			checkValue("pcBundle", pcBundle, {3{32'h30023002}}); // stall no-ops
			checkValue("pcStep", pcStep, 4'd0);
		end
		waitOk("line fill");
		noteLoaded(line);
		noteLoaded(line + 28'd1);
		checkValue("pcBundle", pcBundle, expectedWindow(addr));
		checkValue("pcStep", pcStep, expectedStep(addr, wex));
	endtask

	task automatic runFlush();
		flush = 1'b1;
		@(posedge clock);
		#1;
		flush = 1'b0;
		for (int i = 0; i < 128; i++)
			validModel[i] = 1'b0;
		settleHeld();
	endtask

	task automatic readVectors();
		int          fd;
		int          n;
		int          ch;
		logic [7:0]  code;
		logic [31:0] a;
		logic [31:0] b;
		fd = $fopen("tests/icacheVectors.txt", "r");
		if (fd == 0)
			failRun("Could not open the vector file tests/icacheVectors.txt");
		n = $fscanf(fd, " %c", code);
		while (n == 1)
		begin
			a = '0;
			b = '0;
			if (code == "#")
			begin
				ch = $fgetc(fd);
				while ((ch != 10) && (ch != -1))
					ch = $fgetc(fd);
			end
			else if (code == "M")
			begin
				n = $fscanf(fd, "%h %h", a, b);
				writeWord(a[8:0], b, 1'b1);
			end
			else
			begin
				if (code != "X")
					n = $fscanf(fd, "%h %h", a, b);
				cmdQ.push_back(code);
				argAQ.push_back(a);
				argBQ.push_back(b);
			end
			n = $fscanf(fd, " %c", code);
		end
		$fclose(fd);
	endtask

	// every slot the cache puts on the ring is idle or one of its own line loads
	always @(negedge clock)
	begin
		if (!reset)
		begin
			if (cacheOpm == ringPkg::opmLoadLine)
			begin
				checkValue("ringSeqOut node", cacheSeq[15:8], ringPkg::nodeId);
				checkValue("ringSeqOut bank", cacheSeq[7:6], {1'b0, cacheAddr[4]}); // odd line 01
				checkValue("ringAddrOut offset", cacheAddr[3:0], 4'h0);
				checkValue("ringDataOut", cacheData, '0);
			end
			else
				checkValue("ringOpmOut", cacheOpm, ringPkg::opmIdle);
		end
	end

	initial
	begin
		clock     = 1'b0;
		reset     = 1'b1;
		pc        = '0;
		pcHold    = 1'b1;
		wexEnable = 1'b0;
		flush     = 1'b0;
		lastPc    = '0; // reset leaves PC 0 in the address register
		lfsrState = 16'd37358;
		for (int i = 0; i < 128; i++)
		begin
			validModel[i] = 1'b0;
			tagModel[i]   = '0;
		end
		for (int i = 0; i < memWordCount; i++)
			writeWord(9'(i), fillWord(9'(i)), 1'b1);
		readVectors();
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;
		settleHeld();
		while (cmdQ.size() > 0)
		begin
			cmd  = cmdQ.pop_front();
			argA = argAQ.pop_front();
			argB = argBQ.pop_front();
			case (cmd)
				"F": runFetch(argA, argB[0]);
				"X": runFlush();
				"W": writeWord(argA[8:0], argB, 1'b0); // cached copies stay stale
				default: failRun("Unknown command letter in the vector file");
			endcase
		end
		for (int r = 0; r < randomFetches; r++)
		begin
			pcBits = drawBits(10);
			wexBit = drawBits(1);
			runFetch({21'd0, pcBits[9:0], 1'b0}, wexBit[0]);
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== tests/icacheVectors.txt ====
# M word-index data is an image word, W word-index data a later memory write
# F pc wex is a fetch, X a flush
M 020 1111E400
M 021 2222E400
M 022 3333E000
M 023 44441234
M 027 6666F400
M 028 5555F800
F 00000080 0
F 00000080 1
F 00000084 1
F 0000008C 0
F 0000009C 1
W 021 AAAA1234
F 00000080 1
X
F 00000080 1

// ==== tests/ringMemoryModel.sv ====
// ring memory model that answers line loads from a word image
`timescale 1ns/100ps

module ringMemoryModel (
	input  logic             clock,
	input  logic             reset,
	input  ringPkg::ringOpm  opmIn,
	input  ringPkg::ringSeq  seqIn,
	input  ringPkg::ringAddr addrIn,
	output ringPkg::ringOpm  opmOut,
	output ringPkg::ringSeq  seqOut,
	output ringPkg::ringAddr addrOut,
	output ringPkg::ringData dataOut
);

	localparam int memWordCount = 512;

	logic [31:0]     memWords [memWordCount]; // image written by the testbench
	logic [8:0]      wordBase;
	ringPkg::ringOpm respOpm;

	assign wordBase = {addrIn[10:4], 2'b00}; // first word of the line, wraps at 2 KB
	assign respOpm  = {8'h00, ringPkg::respClass, ringPkg::respOk, 4'h0};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			opmOut  <= ringPkg::opmIdle;
			seqOut  <= '0;
			addrOut <= '0;
			dataOut <= '0;
		end
		else if (opmIn == ringPkg::opmLoadLine)
		begin
			opmOut  <= respOpm;
			seqOut  <= seqIn; // node, bank and tag go back unchanged
			addrOut <= addrIn;
			dataOut <= {memWords[wordBase + 9'd3], memWords[wordBase + 9'd2],
				memWords[wordBase + 9'd1], memWords[wordBase]};
		end
		else
		begin
			opmOut  <= ringPkg::opmIdle;
			seqOut  <= '0;
			addrOut <= '0;
			dataOut <= '0;
		end
	end

endmodule
